// ==== dv/tb_udp_loopback.sv ====
// UDP loopback testbench
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module tb_udp_loopback;

  localparam int num_frames    = 40;
  localparam int beat_timeout  = 1000;
  localparam int drain_timeout = 20000;

  logic                           clk;
  logic                           rst;
  logic                           hdr_valid;
  udp_loopback_pkg::udp_port_t    hdr_dest_port;
  udp_loopback_pkg::narrow_data_t in_data;
  udp_loopback_pkg::narrow_keep_t in_keep;
  logic                           in_valid;
  logic                           in_last;
  logic                           in_ready;
  udp_loopback_pkg::narrow_data_t out_data;
  udp_loopback_pkg::narrow_keep_t out_keep;
  logic                           out_valid;
  logic                           out_last;
  logic                           out_ready;
  logic [7:0]                     led;

  integer seed;
  int     checker_errors;
  logic   in_fired;
  logic   timed_out;

  udp_loopback_top u_udp_loopback_top (
    .clk           (clk),
    .rst           (rst),
    .hdr_valid     (hdr_valid),
    .hdr_dest_port (hdr_dest_port),
    .in_data       (in_data),
    .in_keep       (in_keep),
    .in_valid      (in_valid),
    .in_last       (in_last),
    .in_ready      (in_ready),
    .out_data      (out_data),
    .out_keep      (out_keep),
    .out_valid     (out_valid),
    .out_last      (out_last),
    .out_ready     (out_ready),
    .led           (led)
  );

  udp_loopback_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .hdr_valid     (hdr_valid),
    .hdr_dest_port (hdr_dest_port),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_data      (out_data),
    .out_keep      (out_keep),
    .out_valid     (out_valid),
    .out_last      (out_last),
    .out_ready     (out_ready),
    .led           (led),
    .errors        (checker_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Input handshake seen at the edge, then fresh out_ready
  task automatic next_cycle();
    @(posedge clk);
    in_fired = in_valid && in_ready;
    #1;
    out_ready = ($unsigned($random(seed)) % 4) != 0;
  endtask

  task automatic send_beat(input udp_loopback_pkg::narrow_data_t data,
                           input udp_loopback_pkg::narrow_keep_t keep,
                           input logic last);
    int waited;
    waited   = 0;
    in_data  = data;
    in_keep  = keep;
    in_last  = last;
    in_valid = 1'b1;
    in_fired = 1'b0;
    while (!in_fired && !timed_out) begin
      next_cycle();
      waited++;
      if (!in_fired && waited >= beat_timeout) begin
        $display("Timeout: input beat not accepted within %0d cycles", beat_timeout);
        timed_out = 1'b1;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic send_frame();
    logic                           match;
    int                             len;
    int                             gap;
    udp_loopback_pkg::udp_port_t    port;
    udp_loopback_pkg::narrow_data_t data;
    udp_loopback_pkg::narrow_keep_t keep;
    logic [7:0]                     b;
    gap = $unsigned($random(seed)) % 6;
    repeat (gap) next_cycle();
    match = ($unsigned($random(seed)) % 2) == 1;
    port  = 16'($random(seed));
    if (match) begin
      port = `UDP_LOOPBACK_PORT;
    end else if (port == `UDP_LOOPBACK_PORT) begin
      port = port + 16'd1;
    end
    len = 1 + $unsigned($random(seed)) % 200;
    hdr_valid     = 1'b1;
    hdr_dest_port = port;
    next_cycle();
    hdr_valid = 1'b0;
    for (int pos = 0; pos < len && !timed_out; pos += `UDP_NARROW_BYTES) begin
      data = '0;
      keep = '0;
      for (int i = 0; i < `UDP_NARROW_BYTES && pos + i < len; i++) begin
        b = 8'($random(seed));
        data[i*8 +: 8] = b;
        keep[i] = 1'b1;
        if (match) begin
          u_checker.push_byte(b, pos + i == len - 1);
        end
      end
      send_beat(data, keep, pos + `UDP_NARROW_BYTES >= len);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!timed_out && (u_checker.pending_bytes() != 0 || out_valid)) begin
      next_cycle();
      waited++;
      if (waited >= drain_timeout) begin
        $display("Timeout: %0d expected bytes never reached the output",
                 u_checker.pending_bytes());
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    seed          = 32'h8b0e;
    timed_out     = 1'b0;
    in_fired      = 1'b0;
    rst           = 1'b1;
    hdr_valid     = 1'b0;
    hdr_dest_port = '0;
    in_data       = '0;
    in_keep       = '0;
    in_valid      = 1'b0;
    in_last       = 1'b0;
    out_ready     = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int f = 0; f < num_frames && !timed_out; f++) begin
      send_frame();
    end
    wait_drain();
    // Let the last LED update be checked
    repeat (3) next_cycle();
    $display("Run finished: %0d checker errors, %0d timeouts", checker_errors, timed_out);
    if (checker_errors == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== dv/udp_loopback_checker.sv ====
// UDP loopback output checker
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module udp_loopback_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           hdr_valid,
  input  udp_loopback_pkg::udp_port_t    hdr_dest_port,
  input  logic                           in_valid,
  input  logic                           in_ready,
  input  udp_loopback_pkg::narrow_data_t out_data,
  input  udp_loopback_pkg::narrow_keep_t out_keep,
  input  logic                           out_valid,
  input  logic                           out_last,
  input  logic                           out_ready,
  input  logic [7:0]                     led,
  output int                             errors
);

  // Expected bytes in order, bit 8 marks a frame's final byte
  logic [8:0]                     exp_q [$];
  int                             error_count = 0;
  logic                           rst_d;
  logic                           drop_frame;
  logic                           prev_stall;
  udp_loopback_pkg::narrow_data_t prev_data;
  udp_loopback_pkg::narrow_keep_t prev_keep;
  logic                           prev_last;
  logic                           exp_first;
  logic                           led_known;
  logic [7:0]                     led_exp;

  assign errors = error_count;

  function automatic int pending_bytes();
    return exp_q.size();
  endfunction

  task automatic push_byte(input logic [7:0] b, input logic last_b);
    exp_q.push_back({last_b, b});
  endtask

  task automatic report_mismatch(input string what);
    $display("mismatch at %0t: %s", $time, what);
    error_count++;
  endtask

  // Rebuild the expected beat from the model, up to one frame end
  task automatic check_beat();
    logic [8:0]                     ent;
    udp_loopback_pkg::narrow_keep_t exp_keep;
    logic                           exp_last;
    exp_keep = '0;
    exp_last = 1'b0;
    if (exp_q.size() == 0) begin
      $display("Output beat at %0t arrived with no frame expected", $time);
      error_count++;
      return;
    end
    for (int i = 0; i < `UDP_NARROW_BYTES && !exp_last && exp_q.size() > 0; i++) begin
      ent = exp_q.pop_front();
      exp_keep[i] = 1'b1;
      exp_last = ent[8];
      if (i == 0 && exp_first) begin
        led_exp   <= ent[7:0];
        led_known <= 1'b1;
      end
      if (out_data[i*8 +: 8] !== ent[7:0]) begin
        report_mismatch($sformatf("byte %0d got %h expected %h", i, out_data[i*8 +: 8],
                                  ent[7:0]));
      end
    end
    if (out_keep !== exp_keep) begin
      report_mismatch($sformatf("keep got %b expected %b", out_keep, exp_keep));
    end
    if (out_last !== exp_last) begin
      report_mismatch($sformatf("last got %b expected %b", out_last, exp_last));
    end
    exp_first <= exp_last;
  endtask

  always @(posedge clk) begin
    rst_d <= rst;
    if (rst) begin
      drop_frame <= 1'b0;
      prev_stall <= 1'b0;
      exp_first  <= 1'b1;
      led_known  <= 1'b0;
    end else begin
      if (rst_d && led !== 8'h00) begin
        report_mismatch($sformatf("led %h after reset", led));
      end
      // Dropped frames are never back-pressured
      if (drop_frame && in_valid && !in_ready) begin
        report_mismatch("in_ready low during a dropped frame");
      end
      if (hdr_valid) begin
        drop_frame <= hdr_dest_port != udp_loopback_pkg::udp_port_t'(`UDP_LOOPBACK_PORT);
      end
      if (led_known && led !== led_exp) begin
        report_mismatch($sformatf("led got %h expected %h", led, led_exp));
      end
      // Stalled beat must hold
      if (prev_stall && (!out_valid || out_data !== prev_data || out_keep !== prev_keep ||
                         out_last !== prev_last)) begin
        report_mismatch("output beat changed while stalled");
      end
      prev_stall <= out_valid && !out_ready;
      prev_data  <= out_data;
      prev_keep  <= out_keep;
      prev_last  <= out_last;
      if (out_valid && out_ready) begin
        check_beat();
      end
    end
  end

endmodule

// ==== hdl/port_filter.sv ====
// UDP destination port filter
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module port_filter (
  input  logic                         clk,
  input  logic                         rst,
  // Header strobe, one cycle ahead of the payload
  input  logic                         hdr_valid,
  input  udp_loopback_pkg::udp_port_t  hdr_dest_port,
  // Received payload
  input  udp_loopback_pkg::narrow_data_t in_data,
  input  udp_loopback_pkg::narrow_keep_t in_keep,
  input  logic                         in_valid,
  input  logic                         in_last,
  output logic                         in_ready,
  // Payload of matching frames only
  output udp_loopback_pkg::narrow_data_t flt_data,
  output udp_loopback_pkg::narrow_keep_t flt_keep,
  output logic                         flt_valid,
  output logic                         flt_last,
  input  logic                         flt_ready
);

  logic port_hit;
  logic match;
  logic in_fire;

  assign port_hit = hdr_dest_port == udp_loopback_pkg::udp_port_t'(`UDP_LOOPBACK_PORT);
  assign in_fire  = in_valid && in_ready;

  // Match flag for the open frame
  // A new header wins over the end of the previous frame
  always_ff @(posedge clk) begin
    if (rst) begin
      match <= 1'b0;
    end else if (hdr_valid) begin
      match <= port_hit;
    end else if (in_fire && in_last) begin
      match <= 1'b0;
    end
  end

  // Payload passes straight through, only the handshake is gated
  assign flt_data  = in_data;
  assign flt_keep  = in_keep;
  assign flt_last  = in_last;
  assign flt_valid = in_valid && match;

  // Non-matching beats are accepted and dropped
  assign in_ready  = match ? flt_ready : 1'b1;

endmodule

// ==== hdl/udp_loopback_config.svh ====
// UDP loopback configuration
`ifndef UDP_LOOPBACK_CONFIG_SVH
`define UDP_LOOPBACK_CONFIG_SVH

// Bytes per beat on the 64-bit receive and transmit streams
`define UDP_NARROW_BYTES 8

// Bytes per word on the internal 512-bit path
`define UDP_WIDE_BYTES 64

// Destination port whose payload is returned
`define UDP_LOOPBACK_PORT 16'd1234

// Wide words held by the transmit FIFO
`define UDP_FIFO_DEPTH 16

`endif

// ==== hdl/udp_loopback_pkg.sv ====
// UDP loopback stream types
`include "udp_loopback_config.svh"

package udp_loopback_pkg;

  // Narrow stream, one beat per cycle
  typedef logic [`UDP_NARROW_BYTES*8-1:0] narrow_data_t;
  typedef logic [`UDP_NARROW_BYTES-1:0] narrow_keep_t;

  // Wide words between packer and unpacker
  typedef logic [`UDP_WIDE_BYTES*8-1:0] wide_data_t;
  typedef logic [`UDP_WIDE_BYTES-1:0] wide_keep_t;

  // UDP port number as carried in the header
  typedef logic [15:0] udp_port_t;

endpackage

// ==== hdl/udp_loopback_top.sv ====
// UDP loopback datapath
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module udp_loopback_top (
  input  logic                           clk,
  input  logic                           rst,
  // Received UDP header
  input  logic                           hdr_valid,
  input  udp_loopback_pkg::udp_port_t    hdr_dest_port,
  // Received payload
  input  udp_loopback_pkg::narrow_data_t in_data,
  input  udp_loopback_pkg::narrow_keep_t in_keep,
  input  logic                           in_valid,
  input  logic                           in_last,
  output logic                           in_ready,
  // Returned payload
  output udp_loopback_pkg::narrow_data_t out_data,
  output udp_loopback_pkg::narrow_keep_t out_keep,
  output logic                           out_valid,
  output logic                           out_last,
  input  logic                           out_ready,
  output logic [7:0]                     led
);

  udp_loopback_pkg::narrow_data_t flt_data;
  udp_loopback_pkg::narrow_keep_t flt_keep;
  logic                           flt_valid;
  logic                           flt_last;
  logic                           flt_ready;

  udp_loopback_pkg::wide_data_t   wide_data;
  udp_loopback_pkg::wide_keep_t   wide_keep;
  logic                           wide_valid;
  logic                           wide_last;
  logic                           wide_ready;

  udp_loopback_pkg::wide_data_t   fifo_data;
  udp_loopback_pkg::wide_keep_t   fifo_keep;
  logic                           fifo_valid;
  logic                           fifo_last;
  logic                           fifo_ready;

  logic                           first_beat;
  logic                           out_fire;

  port_filter u_port_filter (
    .clk           (clk),
    .rst           (rst),
    .hdr_valid     (hdr_valid),
    .hdr_dest_port (hdr_dest_port),
    .in_data       (in_data),
    .in_keep       (in_keep),
    .in_valid      (in_valid),
    .in_last       (in_last),
    .in_ready      (in_ready),
    .flt_data      (flt_data),
    .flt_keep      (flt_keep),
    .flt_valid     (flt_valid),
    .flt_last      (flt_last),
    .flt_ready     (flt_ready)
  );

  width_upsizer u_width_upsizer (
    .clk        (clk),
    .rst        (rst),
    .flt_data   (flt_data),
    .flt_keep   (flt_keep),
    .flt_valid  (flt_valid),
    .flt_last   (flt_last),
    .flt_ready  (flt_ready),
    .wide_data  (wide_data),
    .wide_keep  (wide_keep),
    .wide_valid (wide_valid),
    .wide_last  (wide_last),
    .wide_ready (wide_ready)
  );

  wide_fifo #(
    .depth (`UDP_FIFO_DEPTH)
  ) u_wide_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_data  (wide_data),
    .wr_keep  (wide_keep),
    .wr_last  (wide_last),
    .wr_valid (wide_valid),
    .wr_ready (wide_ready),
    .rd_data  (fifo_data),
    .rd_keep  (fifo_keep),
    .rd_last  (fifo_last),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready)
  );

  width_downsizer u_width_downsizer (
    .clk       (clk),
    .rst       (rst),
    .rd_data   (fifo_data),
    .rd_keep   (fifo_keep),
    .rd_last   (fifo_last),
    .rd_valid  (fifo_valid),
    .rd_ready  (fifo_ready),
    .out_data  (out_data),
    .out_keep  (out_keep),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

  assign out_fire = out_valid && out_ready;

  // First payload byte of each returned frame onto the LEDs
  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b1;
      led        <= '0;
    end else if (out_fire) begin
      first_beat <= out_last;
      if (first_beat) begin
        led <= out_data[7:0];
      end
    end
  end

endmodule

// ==== hdl/wide_fifo.sv ====
// First-word-fall-through FIFO for wide words
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module wide_fifo #(
  parameter int depth = `UDP_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst,
  // Write side
  input  udp_loopback_pkg::wide_data_t wr_data,
  input  udp_loopback_pkg::wide_keep_t wr_keep,
  input  logic                         wr_last,
  input  logic                         wr_valid,
  output logic                         wr_ready,
  // Read side, head word always presented
  output udp_loopback_pkg::wide_data_t rd_data,
  output udp_loopback_pkg::wide_keep_t rd_keep,
  output logic                         rd_last,
  output logic                         rd_valid,
  input  logic                         rd_ready
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  udp_loopback_pkg::wide_data_t mem_data [depth];
  udp_loopback_pkg::wide_keep_t mem_keep [depth];
  logic                         mem_last [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign wr_ready = count != (ptr_w + 1)'(depth);
  assign rd_valid = count != '0;
  assign do_wr    = wr_valid && wr_ready;
  assign do_rd    = rd_valid && rd_ready;

  assign rd_data  = mem_data[rd_ptr];
  assign rd_keep  = mem_keep[rd_ptr];
  assign rd_last  = mem_last[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_data[wr_ptr] <= wr_data;
      mem_keep[wr_ptr] <= wr_keep;
      mem_last[wr_ptr] <= wr_last;
    end
  end

  // Pointers wrap at depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + (ptr_w + 1)'(1);
        2'b01:   count <= count - (ptr_w + 1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/width_downsizer.sv ====
// 512-bit to 64-bit stream unpacker
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module width_downsizer (
  input  logic                           clk,
  input  logic                           rst,
  // Wide words from the FIFO
  input  udp_loopback_pkg::wide_data_t   rd_data,
  input  udp_loopback_pkg::wide_keep_t   rd_keep,
  input  logic                           rd_last,
  input  logic                           rd_valid,
  output logic                           rd_ready,
  // Narrow transmit stream
  output udp_loopback_pkg::narrow_data_t out_data,
  output udp_loopback_pkg::narrow_keep_t out_keep,
  output logic                           out_valid,
  output logic                           out_last,
  input  logic                           out_ready
);

  localparam int narrow_bytes = `UDP_NARROW_BYTES;
  localparam int narrow_bits  = narrow_bytes * 8;
  localparam int ratio        = `UDP_WIDE_BYTES / `UDP_NARROW_BYTES;
  localparam int lane_w       = $clog2(ratio);

  udp_loopback_pkg::wide_data_t word_data;
  udp_loopback_pkg::wide_keep_t word_keep;
  logic                         word_last;
  logic                         busy;
  logic [lane_w-1:0]            lane;
  logic [lane_w-1:0]            next_lane;
  logic [ratio-1:0]             lane_used;
  logic                         final_lane;

  // Lanes holding at least one byte
  for (genvar i = 0; i < ratio; i++) begin : g_lane_used
    assign lane_used[i] = |word_keep[i*narrow_bytes +: narrow_bytes];
  end

  // Keep is contiguous, so an empty next lane ends the word
  assign next_lane  = lane + lane_w'(1);
  assign final_lane = (lane == lane_w'(ratio - 1)) || !lane_used[next_lane];

  assign rd_ready  = !busy;
  assign out_valid = busy;
  assign out_data  = word_data[lane*narrow_bits +: narrow_bits];
  assign out_keep  = word_keep[lane*narrow_bytes +: narrow_bytes];
  assign out_last  = word_last && final_lane;

  // Load when idle, then step through lanes
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      lane <= '0;
    end else if (!busy) begin
      if (rd_valid) begin
        busy <= 1'b1;
        lane <= '0;
      end
    end else if (out_ready) begin
      if (final_lane) begin
        busy <= 1'b0;
        lane <= '0;
      end else begin
        lane <= next_lane;
      end
    end
  end

  // Held word
  always_ff @(posedge clk) begin
    if (!busy && rd_valid) begin
      word_data <= rd_data;
      word_keep <= rd_keep;
      word_last <= rd_last;
    end
  end

endmodule

// ==== hdl/width_upsizer.sv ====
// 64-bit to 512-bit stream packer
`timescale 1ns/10ps
`include "udp_loopback_config.svh"

module width_upsizer (
  input  logic                           clk,
  input  logic                           rst,
  // Narrow input from the port filter
  input  udp_loopback_pkg::narrow_data_t flt_data,
  input  udp_loopback_pkg::narrow_keep_t flt_keep,
  input  logic                           flt_valid,
  input  logic                           flt_last,
  output logic                           flt_ready,
  // Packed wide words
  output udp_loopback_pkg::wide_data_t   wide_data,
  output udp_loopback_pkg::wide_keep_t   wide_keep,
  output logic                           wide_valid,
  output logic                           wide_last,
  input  logic                           wide_ready
);

  localparam int narrow_bytes = `UDP_NARROW_BYTES;
  localparam int narrow_bits  = narrow_bytes * 8;
  localparam int ratio        = `UDP_WIDE_BYTES / `UDP_NARROW_BYTES;
  localparam int lane_w       = $clog2(ratio);

  logic [lane_w-1:0] lane;
  logic              in_fire;
  logic              word_done;

  // The word register doubles as the accumulator, so input waits while
  // a finished word sits untaken
  assign flt_ready = !wide_valid || wide_ready;
  assign in_fire   = flt_valid && flt_ready;
  assign word_done = flt_last || (lane == lane_w'(ratio - 1));

  // Lane counter and output valid
  always_ff @(posedge clk) begin
    if (rst) begin
      lane       <= '0;
      wide_valid <= 1'b0;
    end else begin
      if (wide_valid && wide_ready) begin
        wide_valid <= 1'b0;
      end
      if (in_fire) begin
        if (word_done) begin
          lane       <= '0;
          wide_valid <= 1'b1;
        end else begin
          lane <= lane + lane_w'(1);
        end
      end
    end
  end

  // Shift each beat into its lane
  always_ff @(posedge clk) begin
    if (in_fire) begin
      wide_data[lane*narrow_bits +: narrow_bits] <= flt_data;
      if (lane == '0) begin
        // New word, clear enables of the lanes above
        wide_keep <= udp_loopback_pkg::wide_keep_t'(flt_keep);
      end else begin
        wide_keep[lane*narrow_bytes +: narrow_bytes] <= flt_keep;
      end
      if (word_done) begin
        wide_last <= flt_last;
      end
    end
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/udp_loopback_pkg.sv
hdl/port_filter.sv
hdl/width_upsizer.sv
hdl/wide_fifo.sv
hdl/width_downsizer.sv
hdl/udp_loopback_top.sv
dv/udp_loopback_checker.sv
dv/tb_udp_loopback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UDP loopback simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_udp_loopback -Mdir obj_dir -o sim_udp_loopback
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_udp_loopback)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
fi
exit 1
